/* dfp_config_pkg.sv */
package dfp_config_pkg;

    // matching banks
    localparam int NUM_BANKS  = 4;
    localparam int BANK_SEL_W = 2;

    // slots per bank
    localparam int SLOT_W    = 6;
    localparam int NUM_SLOTS = 1 << SLOT_W;

    // bank select at the bottom of the destination, slot right above it
    localparam int BANK_LSB = 0;
    localparam int SLOT_LSB = BANK_LSB + BANK_SEL_W;

    // constant table contents, 3*s + 1 cut to the data width
    function automatic logic [dfp_packet_pkg::DATA_W-1:0] const_value(
        input int unsigned s
    );
        logic [31:0] v;
        v = 3 * s + 1;
        return v[dfp_packet_pkg::DATA_W-1:0];
    endfunction

endpackage

/* dfp_packet_pkg.sv */
package dfp_packet_pkg;

    // input token, 39 bits
    localparam int PKT_IN_W = 39;

    // field widths shared by input and result
    localparam int DEST_W = 18;
    localparam int CZ_W   = 3;
    localparam int DATA_W = 16;

    // input field positions
    localparam int MF_BIT   = 38;
    localparam int DEST_LSB = 20;
    localparam int LR_BIT   = 19;
    localparam int CZ_LSB   = 16;
    localparam int DATA_LSB = 0;

    // result packet, 54 bits
    localparam int PKT_OUT_W = 54;

    // two-operand result
    typedef struct packed {
        logic [DEST_W-1:0] dest;
        logic              lr;
        logic [CZ_W-1:0]   cz;
        logic [DATA_W-1:0] left;
        logic [DATA_W-1:0] right;
    } matched_view_t;

    // one-operand result paired with the table constant
    typedef struct packed {
        logic [DEST_W-1:0] dest;
        logic              lr;
        logic [CZ_W-1:0]   cz;
        logic [DATA_W-1:0] token;
        logic [DATA_W-1:0] cst;
    } const_view_t;

    // same 54-bit word, read as either kind of result
    typedef union packed {
        matched_view_t matched;
        const_view_t   constant;
    } result_word_u;

endpackage

/* match_checker.sv */
`timescale 1ns/100ps

module match_checker (
    input  logic                                  CP,
    input  logic                                  MR,
    input  logic                                  send_in,
    input  logic                                  ack_out,
    input  logic [dfp_packet_pkg::PKT_IN_W-1:0]   pkt_in,
    input  logic                                  send_out,
    input  logic                                  ack_in,
    input  logic [dfp_packet_pkg::PKT_OUT_W-1:0]  pkt_out,
    output int                                    mismatch_cnt,
    output int                                    order_cnt,
    output int                                    unexpected_cnt,
    output int                                    reset_cnt,
    output int                                    pending_cnt
);
    import dfp_packet_pkg::*;

    // results owed by the unit with the oldest at the front
    result_word_u           expected_q [$];
    // first operands waiting per destination
    bit                     waiting [int];
    logic [CZ_W+DATA_W-1:0] parked [int];
    bit                     reset_seen;

    task automatic model_token(input logic [PKT_IN_W-1:0] p);
        result_word_u      w;
        logic [DEST_W-1:0] d;
        logic              lr;
        logic [CZ_W-1:0]   cz;
        logic [DATA_W-1:0] data;
        logic [CZ_W-1:0]   s_cz;
        logic [DATA_W-1:0] s_data;
        int                key;
        d    = p[DEST_LSB +: DEST_W];
        lr   = p[LR_BIT];
        cz   = p[CZ_LSB +: CZ_W];
        data = p[DATA_LSB +: DATA_W];
        key  = int'(d);
        w    = '0;
        if (!p[MF_BIT]) begin
            w.constant.dest  = d;
            w.constant.lr    = lr;
            w.constant.cz    = cz;
            w.constant.token = data;
            // slot sits right above the two bank bits
            w.constant.cst   = 16'(3 * int'(d[7:2]) + 1);
            expected_q.push_back(w);
        end else if (!(waiting.exists(key) && waiting[key])) begin
            waiting[key] = 1'b1;
            parked[key]  = {cz, data};
        end else begin
            waiting[key]     = 1'b0;
            {s_cz, s_data}   = parked[key];
            w.matched.dest   = d;
            w.matched.lr     = lr;
            w.matched.cz     = lr ? cz : s_cz;
            w.matched.left   = lr ? s_data : data;
            w.matched.right  = lr ? data : s_data;
            expected_q.push_back(w);
        end
    endtask

    task automatic check_result(input logic [PKT_OUT_W-1:0] got);
        result_word_u g;
        result_word_u e;
        int           hit;
        int           first_in_bank;
        g             = got;
        hit           = -1;
        first_in_bank = -1;
        foreach (expected_q[i]) begin
            e = expected_q[i];
            if (hit < 0 && e.matched.dest == g.matched.dest) begin
                hit = i;
            end
            if (first_in_bank < 0 && e.matched.dest[1:0] == g.matched.dest[1:0]) begin
                first_in_bank = i;
            end
        end
        if (hit < 0) begin
            $display("%0t: result for destination %h came out with none expected",
                     $time, g.matched.dest);
            unexpected_cnt++;
        end else begin
            e = expected_q[hit];
            if (e !== g) begin
                $display("CHECK FAILED time=%0t signal=pkt_out expected=%h actual=%h",
                         $time, e, got);
                mismatch_cnt++;
            end
            if (first_in_bank != hit) begin
                $display("%0t: bank %0d passed an older result of its own",
                         $time, g.matched.dest[1:0]);
                order_cnt++;
            end
            expected_q.delete(hit);
        end
    endtask

    always @(posedge CP) begin
        if (MR) begin
            // registers are only sure to be cleared after a first edge in reset
            if (reset_seen) begin
                if (send_out !== 1'b0) begin
                    $display("CHECK FAILED time=%0t signal=send_out expected=0 actual=%b",
                             $time, send_out);
                    reset_cnt++;
                end
                if (ack_out !== 1'b1) begin
                    $display("CHECK FAILED time=%0t signal=ack_out expected=1 actual=%b",
                             $time, ack_out);
                    reset_cnt++;
                end
            end
            reset_seen = 1'b1;
            expected_q.delete();
            waiting.delete();
            parked.delete();
        end else begin
            if (send_out && ack_in) begin
                check_result(pkt_out);
            end
            if (send_in && ack_out) begin
                model_token(pkt_in);
            end
        end
        pending_cnt = expected_q.size();
    end

endmodule

/* match_stage.sv */
`timescale 1ns/100ps

module match_stage (
    input  logic                                  CP,
    input  logic                                  MR,
    input  logic                                  send_in,
    output logic                                  ack_out,
    input  logic [dfp_packet_pkg::PKT_IN_W-1:0]   pkt_in,
    output logic                                  send_out,
    input  logic                                  ack_in,
    output logic [dfp_packet_pkg::PKT_OUT_W-1:0]  pkt_out
);
    import dfp_packet_pkg::*;
    import dfp_config_pkg::*;

    // token fields
    logic              mf;
    logic [DEST_W-1:0] dest;
    logic              lr;
    logic [CZ_W-1:0]   cz;
    logic [DATA_W-1:0] data;
    logic [SLOT_W-1:0] slot;

    // waiting operands, cz kept above data
    logic [CZ_W+DATA_W-1:0] store_mem [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]   present;
    logic [DATA_W-1:0]      const_tab [NUM_SLOTS];
    logic [CZ_W-1:0]        stored_cz;
    logic [DATA_W-1:0]      stored_data;

    // handshake and control
    logic take_in;
    logic take_out;
    logic hit;
    logic store_op;
    logic load_out;
    logic out_valid;

    result_word_u next_word;
    result_word_u out_word;

    assign mf   = pkt_in[MF_BIT];
    assign dest = pkt_in[DEST_LSB +: DEST_W];
    assign lr   = pkt_in[LR_BIT];
    assign cz   = pkt_in[CZ_LSB +: CZ_W];
    assign data = pkt_in[DATA_LSB +: DATA_W];
    assign slot = dest[SLOT_LSB +: SLOT_W];

    // constant ROM, one entry per slot
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_const
        assign const_tab[s] = const_value(s);
    end

    // room when the output register is empty or leaving now
    assign ack_out  = !out_valid || ack_in;
    assign take_in  = send_in && ack_out;
    assign take_out = out_valid && ack_in;

    assign hit                      = present[slot];
    assign {stored_cz, stored_data} = store_mem[slot];

    // first operand of a pair is parked, everything else yields a result
    assign store_op = take_in && mf && !hit;
    assign load_out = take_in && (!mf || hit);

    always_comb begin
        next_word = '0;
        if (mf) begin
            // operands ordered by the arriving token's LR flag
            next_word.matched.dest  = dest;
            next_word.matched.lr    = lr;
            next_word.matched.cz    = lr ? cz : stored_cz;
            next_word.matched.left  = lr ? stored_data : data;
            next_word.matched.right = lr ? data : stored_data;
        end else begin
            next_word.constant.dest  = dest;
            next_word.constant.lr    = lr;
            next_word.constant.cz    = cz;
            next_word.constant.token = data;
            next_word.constant.cst   = const_tab[slot];
        end
    end

    // presence toggles on every paired token to the slot
    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            present <= '0;
        end else if (take_in && mf) begin
            present[slot] <= !hit;
        end
    end

    always_ff @(posedge CP) begin
        if (store_op) begin
            store_mem[slot] <= {cz, data};
        end
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            out_valid <= 1'b0;
        end else if (load_out) begin
            out_valid <= 1'b1;
        end else if (take_out) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge CP) begin
        if (load_out) begin
            out_word <= next_word;
        end
    end

    assign send_out = out_valid;
    assign pkt_out  = out_word;

endmodule

/* matching_unit.sv */
`timescale 1ns/100ps

module matching_unit (
    input  logic                                  CP,
    input  logic                                  MR,
    input  logic                                  send_in,
    input  logic [dfp_packet_pkg::PKT_IN_W-1:0]   pkt_in,
    output logic                                  ack_out,
    output logic                                  send_out,
    output logic [dfp_packet_pkg::PKT_OUT_W-1:0]  pkt_out,
    input  logic                                  ack_in
);
    import dfp_packet_pkg::*;
    import dfp_config_pkg::*;

    // dispatcher to banks
    logic [NUM_BANKS-1:0] bank_send;
    logic [NUM_BANKS-1:0] bank_ack;

    // banks to merger
    logic [NUM_BANKS-1:0]                stage_send;
    logic [NUM_BANKS-1:0]                stage_ack;
    logic [NUM_BANKS-1:0][PKT_OUT_W-1:0] stage_pkt;

    packet_dispatch u_dispatch (
        .pkt_in    (pkt_in),
        .send_in   (send_in),
        .ack_out   (ack_out),
        .bank_send (bank_send),
        .bank_ack  (bank_ack)
    );

    // every bank sees the same input packet
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        match_stage u_stage (
            .CP       (CP),
            .MR       (MR),
            .send_in  (bank_send[b]),
            .ack_out  (bank_ack[b]),
            .pkt_in   (pkt_in),
            .send_out (stage_send[b]),
            .ack_in   (stage_ack[b]),
            .pkt_out  (stage_pkt[b])
        );
    end

    packet_merge u_merge (
        .CP        (CP),
        .MR        (MR),
        .bank_send (stage_send),
        .bank_ack  (stage_ack),
        .bank_pkt  (stage_pkt),
        .send_out  (send_out),
        .ack_in    (ack_in),
        .pkt_out   (pkt_out)
    );

endmodule

/* packet_dispatch.sv */
`timescale 1ns/100ps

module packet_dispatch (
    input  logic [dfp_packet_pkg::PKT_IN_W-1:0]  pkt_in,
    input  logic                                  send_in,
    output logic                                  ack_out,
    output logic [dfp_config_pkg::NUM_BANKS-1:0]  bank_send,
    input  logic [dfp_config_pkg::NUM_BANKS-1:0]  bank_ack
);
    import dfp_packet_pkg::*;
    import dfp_config_pkg::*;

    logic [BANK_SEL_W-1:0] sel;

    // bank number from the low destination bits
    assign sel = pkt_in[DEST_LSB + BANK_LSB +: BANK_SEL_W];

    // only the addressed bank sees send
    always_comb begin
        bank_send      = '0;
        bank_send[sel] = send_in;
    end

    // source stalls on the addressed bank alone
    assign ack_out = bank_ack[sel];

endmodule

/* packet_merge.sv */
`timescale 1ns/100ps

module packet_merge (
    input  logic                                  CP,
    input  logic                                  MR,
    input  logic [dfp_config_pkg::NUM_BANKS-1:0]  bank_send,
    output logic [dfp_config_pkg::NUM_BANKS-1:0]  bank_ack,
    input  logic [dfp_config_pkg::NUM_BANKS-1:0]
                 [dfp_packet_pkg::PKT_OUT_W-1:0]  bank_pkt,
    output logic                                  send_out,
    input  logic                                  ack_in,
    output logic [dfp_packet_pkg::PKT_OUT_W-1:0]  pkt_out
);
    import dfp_config_pkg::*;

    // last granted bank
    logic [BANK_SEL_W-1:0] rr_ptr;
    logic [BANK_SEL_W-1:0] grant_idx;
    logic                  grant_valid;
    logic                  can_load;
    logic                  accept;
    logic                  out_valid;

    // search starts one past the previous winner
    always_comb begin
        logic [BANK_SEL_W-1:0] idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = rr_ptr + BANK_SEL_W'(i);
            if (!grant_valid && bank_send[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    assign can_load = !out_valid || ack_in;
    assign accept   = grant_valid && can_load;

    // ack goes to the winner only
    always_comb begin
        bank_ack            = '0;
        bank_ack[grant_idx] = accept;
    end

    always_ff @(posedge CP or posedge MR) begin
        if (MR) begin
            // bank 0 is first in line after reset
            rr_ptr    <= '1;
            out_valid <= 1'b0;
        end else if (accept) begin
            rr_ptr    <= grant_idx;
            out_valid <= 1'b1;
        end else if (ack_in) begin
            out_valid <= 1'b0;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge CP) begin
        if (accept) begin
            pkt_out <= bank_pkt[grant_idx];
        end
    end

    assign send_out = out_valid;

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_matching_unit -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    && grep -q "^Test completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

/* tb.f */
dfp_packet_pkg.sv
dfp_config_pkg.sv
packet_dispatch.sv
match_stage.sv
packet_merge.sv
matching_unit.sv
match_checker.sv
tb_matching_unit.sv

/* tb_matching_unit.sv */
`timescale 1ns/100ps

module tb_matching_unit;
    import dfp_packet_pkg::*;

    localparam int NUM_TOKENS     = 600;
    localparam int POOL_SIZE      = 16;
    localparam int TIMEOUT_CYCLES = 20 * NUM_TOKENS + 200;

    logic                 CP;
    logic                 MR;
    logic                 send_in;
    logic [PKT_IN_W-1:0]  pkt_in;
    logic                 ack_out;
    logic                 send_out;
    logic [PKT_OUT_W-1:0] pkt_out;
    logic                 ack_in;

    int seed;
    int cycles;
    int sent;
    bit took;

    // error counts kept by the checker
    int mismatch_cnt;
    int order_cnt;
    int unexpected_cnt;
    int reset_cnt;
    int pending_cnt;

    matching_unit dut0 (
        .CP       (CP),
        .MR       (MR),
        .send_in  (send_in),
        .pkt_in   (pkt_in),
        .ack_out  (ack_out),
        .send_out (send_out),
        .pkt_out  (pkt_out),
        .ack_in   (ack_in)
    );

    match_checker chk0 (
        .CP             (CP),
        .MR             (MR),
        .send_in        (send_in),
        .ack_out        (ack_out),
        .pkt_in         (pkt_in),
        .send_out       (send_out),
        .ack_in         (ack_in),
        .pkt_out        (pkt_out),
        .mismatch_cnt   (mismatch_cnt),
        .order_cnt      (order_cnt),
        .unexpected_cnt (unexpected_cnt),
        .reset_cnt      (reset_cnt),
        .pending_cnt    (pending_cnt)
    );

    always #5 CP = ~CP;

    // small pool, low 8 bits all distinct so no two entries share a slot
    function automatic logic [DEST_W-1:0] pool_dest(input int k);
        logic [7:0] low;
        logic [9:0] high;
        low  = 8'(k * 13);
        high = 10'(k * 71 + 3);
        return {high, low};
    endfunction

    task automatic build_token(output logic [PKT_IN_W-1:0] p);
        int          k;
        logic [31:0] r;
        k = int'($unsigned($random(seed)) % POOL_SIZE);
        r = $random(seed);
        p = '0;
        // roughly one token in four is a single-operand one
        p[MF_BIT]                 = ($unsigned($random(seed)) % 4) != 0;
        p[DEST_LSB +: DEST_W]     = pool_dest(k);
        p[LR_BIT]                 = r[0];
        p[CZ_LSB +: CZ_W]         = r[3:1];
        p[DATA_LSB +: DATA_W]     = r[31:16];
    endtask

    task automatic print_summary();
        $display("errors: mismatch %0d, order %0d, unexpected %0d, reset %0d, missing %0d",
                 mismatch_cnt, order_cnt, unexpected_cnt, reset_cnt, pending_cnt);
    endtask

    always @(posedge CP) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d tokens sent", cycles, sent);
            print_summary();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        CP      = 1'b0;
        MR      = 1'b1;
        send_in = 1'b0;
        pkt_in  = '0;
        ack_in  = 1'b0;
        seed    = 8535;
        sent    = 0;
        took    = 1'b0;
        repeat (8) @(posedge CP);
        @(negedge CP);
        MR = 1'b0;

        // one token held until taken, random gaps and random back-pressure
        while (sent < NUM_TOKENS) begin
            if (took) begin
                send_in = 1'b0;
            end
            ack_in = ($unsigned($random(seed)) % 10) >= 3;
            if (!send_in && ($unsigned($random(seed)) % 4) != 0) begin
                build_token(pkt_in);
                send_in = 1'b1;
            end
            @(posedge CP);
            took = send_in && ack_out;
            if (took) begin
                sent++;
            end
            @(negedge CP);
        end
        send_in = 1'b0;

        // drain what is still in flight
        while (pending_cnt != 0 || send_out) begin
            ack_in = ($unsigned($random(seed)) % 10) >= 3;
            @(negedge CP);
        end
        // a few idle cycles to catch a duplicate
        ack_in = 1'b1;
        repeat (10) @(negedge CP);

        print_summary();
        if (mismatch_cnt + order_cnt + unexpected_cnt + reset_cnt + pending_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
